/* sources.f */
source/pwrite_pkg.sv
source/req_fifo.sv
source/rmw_slot_heap.sv
source/read_port_mux.sv
source/write_merge.sv
source/pwrite_shim.sv
tb/tb_pwrite_shim.sv

/* Makefile */
# Verilator build and run of the partial write shim testbench

LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module tb_pwrite_shim -f sources.f -o sim_pwrite_shim

# The run passes only when the log holds the pass line
run: compile
	./obj_dir/sim_pwrite_shim | tee $(LOG)
	grep -q "All checks passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* tb/tb_pwrite_shim.sv */
/*
 * Testbench for the partial write shim
 * Random reads and byte-masked writes against a memory model with random
 * latency and almost-full levels, checked against a shadow copy of memory
 */

`timescale 1ns/100ps

module tb_pwrite_shim;
    import pwrite_pkg::*;

    // ====================
    // Test sizing
    // ====================

    localparam int LINE_IDX_BITS = 6;
    localparam int MEM_LINES = 1 << LINE_IDX_BITS;
    localparam int N_PHASES = 4;
    localparam int WR_PER_PHASE = 24;
    localparam int RD_PER_PHASE = 16;
    // The first phase opens with enough partial writes to reuse every slot
    localparam int BURST_WRITES = N_SLOTS + 2;
    localparam int N_REQUESTS = N_PHASES * (WR_PER_PHASE + RD_PER_PHASE);
    // Generous bound of twenty cycles per request
    localparam int TIMEOUT_CYCLES = 20 * N_REQUESTS;
    localparam logic [15:0] SEED = 16'd55481;

    logic clk = 1'b0;
    logic reset;
    logic afu_rd_valid;
    t_addr afu_rd_addr;
    t_tag afu_rd_tag;
    logic afu_wr_valid;
    t_addr afu_wr_addr;
    t_line afu_wr_data;
    t_mask afu_wr_mask;
    logic afu_rd_almost_full;
    logic afu_wr_almost_full;
    logic afu_rsp_valid;
    t_tag afu_rsp_tag;
    t_line afu_rsp_data;
    logic mem_rd_valid;
    t_addr mem_rd_addr;
    t_tag mem_rd_tag;
    logic mem_wr_valid;
    t_addr mem_wr_addr;
    t_line mem_wr_data;
    logic mem_rd_almost_full;
    logic mem_wr_almost_full;
    logic mem_rsp_valid;
    t_tag mem_rsp_tag;
    t_line mem_rsp_data;

    // Memory model contents and the shadow the reference model keeps
    t_line mem [MEM_LINES];
    t_line shadow [MEM_LINES];
    bit pending [MEM_LINES];
    bit in_phase [MEM_LINES];
    int wr_list [WR_PER_PHASE];

    // Reads accepted by the memory model are answered in order
    int rd_idx_q [$];
    t_tag rd_tag_q [$];
    int rd_due_q [$];
    // AFU reads still waiting for their response
    t_tag exp_tag_q [$];
    t_line exp_data_q [$];

    logic [15:0] lfsr_state;
    logic [TAG_BITS-2:0] tag_count;
    int cycles;
    int outstanding;
    int wr_total;
    int partial_total;
    int inj_total;
    int mem_wr_total;
    int rd_after_af;
    int wr_after_af;

    always #5 clk = ~clk;

    pwrite_shim i_dut (.*);

    // ====================
    // Helpers
    // ====================

    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        // Taps 16, 14, 13 and 11 give a maximal length sequence
        return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
    endfunction

    // Steps the LFSR once per bit and shifts each new bit in at the LSB
    function automatic logic [63:0] rand_bits(input int count);
        logic [63:0] value;
        value = '0;
        for (int i = 0; i < count; i++)
        begin
            lfsr_state = lfsr_step(lfsr_state);
            value = {value[62:0], lfsr_state[0]};
        end
        return value;
    endfunction

    task automatic check_equal(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        if (actual !== expected)
        begin
            $display("Error at %0t ns: %s, got %0h, expected %0h", $time, what, actual,
                     expected);
            $display("Checks failed");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    // Runs one clock cycle that samples what the DUT did, runs the memory model
    // and returns the AFU strobes to idle so a caller may raise them again
    task automatic tick();
        int idx;
        @(posedge clk);
        cycles++;
        if (cycles >= TIMEOUT_CYCLES)
        begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Checks failed");
            $fatal(1, "timeout");
        end

        // Values seen here still belong to the cycle that just ended
        if (mem_rd_valid)
        begin
            check_equal(64'(int'(mem_rd_addr) < MEM_LINES), 64'd1, "memory read address range");
            rd_idx_q.push_back(int'(mem_rd_addr));
            rd_tag_q.push_back(mem_rd_tag);
            rd_due_q.push_back(cycles + 1 + int'(rand_bits(2)));
            if (mem_rd_tag[RMW_TAG_BIT])
            begin
                inj_total++;
            end
        end
        if (mem_wr_valid)
        begin
            check_equal(64'(int'(mem_wr_addr) < MEM_LINES), 64'd1, "memory write address range");
            idx = int'(mem_wr_addr);
            check_equal(64'(pending[idx]), 64'd1, "memory write to a line with no write pending");
            check_equal(mem_wr_data, shadow[idx], $sformatf("memory write data, line %0d", idx));
            mem[idx] = mem_wr_data;
            pending[idx] = 1'b0;
            outstanding--;
            mem_wr_total++;
        end
        if (afu_rsp_valid)
        begin
            check_equal(64'(afu_rsp_tag[RMW_TAG_BIT]), 64'd0, "injected read response at the AFU");
            check_equal(64'(exp_tag_q.size() != 0), 64'd1, "AFU response with no read outstanding");
            check_equal(64'(afu_rsp_tag), 64'(exp_tag_q.pop_front()), "AFU response tag");
            check_equal(afu_rsp_data, exp_data_q.pop_front(), "AFU response data");
        end

        // The AFU read level follows the memory read level
        if (mem_rd_almost_full)
        begin
            check_equal(64'(afu_rd_almost_full), 64'd1,
                        "AFU read almost-full low under memory read back-pressure");
        end
        // A raised write level needs at least that many writes still inside the shim
        if (afu_wr_almost_full)
        begin
            check_equal(64'(outstanding >= WR_FIFO_DEPTH - ALMOST_FULL_SLACK), 64'd1,
                        "AFU write almost-full with the write FIFO short of its level");
        end

        // Requests that follow a raised almost-full level must stay within the slack
        rd_after_af = mem_rd_almost_full ? rd_after_af + int'(mem_rd_valid) : 0;
        wr_after_af = mem_wr_almost_full ? wr_after_af + int'(mem_wr_valid) : 0;
        check_equal(64'(rd_after_af > ALMOST_FULL_SLACK), 64'd0, "memory reads past almost-full");
        check_equal(64'(wr_after_af > ALMOST_FULL_SLACK), 64'd0, "memory writes past almost-full");

        // The oldest read answers once its random delay is over
        if (rd_due_q.size() != 0 && rd_due_q[0] <= cycles)
        begin
            idx = rd_idx_q.pop_front();
            void'(rd_due_q.pop_front());
            mem_rsp_valid <= 1'b1;
            mem_rsp_tag <= rd_tag_q.pop_front();
            mem_rsp_data <= mem[idx];
        end
        else
        begin
            mem_rsp_valid <= 1'b0;
        end
        // Each level holds for about eight cycles before it flips
        mem_rd_almost_full <= mem_rd_almost_full ^ (rand_bits(3) == 64'd0);
        mem_wr_almost_full <= mem_wr_almost_full ^ (rand_bits(3) == 64'd0);
        afu_rd_valid <= 1'b0;
        afu_wr_valid <= 1'b0;
    endtask

    task automatic issue_write(input int idx, input bit force_partial);
        t_line data;
        t_mask mask;
        data = rand_bits(64);
        mask = t_mask'(rand_bits(LINE_BYTES));
        if (force_partial)
        begin
            // Keep at least one byte from the old line
            if (mask == FULL_MASK)
            begin
                mask[0] = 1'b0;
            end
        end
        else if (rand_bits(1) == 64'd1)
        begin
            mask = FULL_MASK;
        end

        // Reference model takes new bytes under the mask and keeps old bytes elsewhere
        for (int i = 0; i < LINE_BYTES; i++)
        begin
            if (mask[i])
            begin
                shadow[idx][8*i +: 8] = data[8*i +: 8];
            end
        end
        pending[idx] = 1'b1;
        outstanding++;
        wr_total++;
        if (mask != FULL_MASK)
        begin
            partial_total++;
        end
        afu_wr_valid <= 1'b1;
        afu_wr_addr <= t_addr'(idx);
        afu_wr_data <= data;
        afu_wr_mask <= mask;
    endtask

    task automatic issue_read();
        int idx;
        // Only lines the current phase leaves alone are read
        idx = int'(rand_bits(LINE_IDX_BITS));
        while (in_phase[idx])
        begin
            idx = int'(rand_bits(LINE_IDX_BITS));
        end
        afu_rd_valid <= 1'b1;
        afu_rd_addr <= t_addr'(idx);
        afu_rd_tag <= {1'b0, tag_count};
        exp_tag_q.push_back({1'b0, tag_count});
        exp_data_q.push_back(shadow[idx]);
        tag_count = tag_count + 1'b1;
    endtask

    // ====================
    // Phases
    // ====================

    task automatic run_phase(input int phase);
        int wr_done;
        int rd_done;
        int idx;
        bit burst;
        // Pick distinct lines so no line has two writes in flight
        for (int i = 0; i < WR_PER_PHASE; i++)
        begin
            idx = int'(rand_bits(LINE_IDX_BITS));
            while (in_phase[idx])
            begin
                idx = int'(rand_bits(LINE_IDX_BITS));
            end
            in_phase[idx] = 1'b1;
            wr_list[i] = idx;
        end

        wr_done = 0;
        rd_done = 0;
        while (wr_done < WR_PER_PHASE || rd_done < RD_PER_PHASE)
        begin
            tick();
            // The first phase opens with a run of partial writes and no reads
            burst = (phase == 0) && (wr_done < BURST_WRITES);
            if (wr_done < WR_PER_PHASE && !afu_wr_almost_full &&
                (burst || rd_done == RD_PER_PHASE || rand_bits(1) == 64'd1))
            begin
                issue_write(wr_list[wr_done], burst);
                wr_done++;
            end
            else if (!burst && rd_done < RD_PER_PHASE && !afu_rd_almost_full)
            begin
                issue_read();
                rd_done++;
            end
        end

        // Let every write land and every read answer
        while (outstanding != 0 || exp_tag_q.size() != 0 || rd_tag_q.size() != 0)
        begin
            tick();
        end
        for (int a = 0; a < MEM_LINES; a++)
        begin
            check_equal(mem[a], shadow[a], $sformatf("line %0d after phase %0d", a, phase));
            in_phase[a] = 1'b0;
        end
    endtask

    initial
    begin
        lfsr_state = SEED;
        tag_count = '0;
        cycles = 0;
        outstanding = 0;
        wr_total = 0;
        partial_total = 0;
        inj_total = 0;
        mem_wr_total = 0;
        rd_after_af = 0;
        wr_after_af = 0;
        for (int a = 0; a < MEM_LINES; a++)
        begin
            mem[a] = rand_bits(64);
            shadow[a] = mem[a];
            pending[a] = 1'b0;
            in_phase[a] = 1'b0;
        end

        reset <= 1'b1;
        afu_rd_valid <= 1'b0;
        afu_rd_addr <= '0;
        afu_rd_tag <= '0;
        afu_wr_valid <= 1'b0;
        afu_wr_addr <= '0;
        afu_wr_data <= '0;
        afu_wr_mask <= '0;
        mem_rd_almost_full <= 1'b0;
        mem_wr_almost_full <= 1'b0;
        mem_rsp_valid <= 1'b0;
        mem_rsp_tag <= '0;
        mem_rsp_data <= '0;
        repeat (4) @(posedge clk);
        reset <= 1'b0;

        for (int p = 0; p < N_PHASES; p++)
        begin
            run_phase(p);
        end

        // Each partial write needs one injected read and each AFU write one memory write
        check_equal(64'(inj_total), 64'(partial_total), "injected reads against partial writes");
        check_equal(64'(mem_wr_total), 64'(wr_total), "memory writes against AFU writes");
        $display("All checks passed");
        $finish;
    end

endmodule

/* source/pwrite_shim.sv */
/*
 * Partial write shim
 * Emulates byte-masked writes with read-modify-write between the AFU
 * request ports and a memory that only takes full-line writes
 */

`timescale 1ns/100ps

module pwrite_shim (
    input  logic              clk,
    input  logic              reset,

    // AFU side
    input  logic              afu_rd_valid,
    input  pwrite_pkg::t_addr afu_rd_addr,
    input  pwrite_pkg::t_tag  afu_rd_tag,
    input  logic              afu_wr_valid,
    input  pwrite_pkg::t_addr afu_wr_addr,
    input  pwrite_pkg::t_line afu_wr_data,
    input  pwrite_pkg::t_mask afu_wr_mask,
    output logic              afu_rd_almost_full,
    output logic              afu_wr_almost_full,
    output logic              afu_rsp_valid,
    output pwrite_pkg::t_tag  afu_rsp_tag,
    output pwrite_pkg::t_line afu_rsp_data,

    // Memory side
    output logic              mem_rd_valid,
    output pwrite_pkg::t_addr mem_rd_addr,
    output pwrite_pkg::t_tag  mem_rd_tag,
    output logic              mem_wr_valid,
    output pwrite_pkg::t_addr mem_wr_addr,
    output pwrite_pkg::t_line mem_wr_data,
    input  logic              mem_rd_almost_full,
    input  logic              mem_wr_almost_full,
    input  logic              mem_rsp_valid,
    input  pwrite_pkg::t_tag  mem_rsp_tag,
    input  pwrite_pkg::t_line mem_rsp_data
);
    import pwrite_pkg::*;

    t_wr_req wr_in;
    t_wr_req wr_head;
    logic wr_not_empty;
    logic wr_deq;

    logic inject_ready;
    logic inj_valid;
    t_addr inj_addr;
    t_slot inj_slot;
    logic head_partial;

    logic has_free;
    t_slot free_slot;
    logic alloc;
    t_wr_req alloc_req;
    logic lookup;
    t_slot lookup_slot;
    logic park_valid;
    t_wr_req park_req;

    logic rsp_rmw_valid;
    t_slot rsp_rmw_slot;
    t_line rsp_data;

    assign wr_in.addr = afu_wr_addr;
    assign wr_in.data = afu_wr_data;
    assign wr_in.mask = afu_wr_mask;

    // Writes wait here until the memory port or a read slot is free
    req_fifo #(
        .t_payload(t_wr_req),
        .DEPTH(WR_FIFO_DEPTH)
    ) wr_fifo (
        .clk(clk),
        .reset(reset),
        .enq(afu_wr_valid),
        .enq_data(wr_in),
        .almost_full(afu_wr_almost_full),
        .first(wr_head),
        .not_empty(wr_not_empty),
        .deq(wr_deq)
    );

    rmw_slot_heap heap (
        .clk(clk),
        .reset(reset),
        .has_free(has_free),
        .free_slot(free_slot),
        .alloc(alloc),
        .alloc_req(alloc_req),
        .lookup(lookup),
        .lookup_slot(lookup_slot),
        .park_valid(park_valid),
        .park_req(park_req)
    );

    read_port_mux rd_mux (
        .clk(clk),
        .reset(reset),
        .afu_rd_valid(afu_rd_valid),
        .afu_rd_addr(afu_rd_addr),
        .afu_rd_tag(afu_rd_tag),
        .afu_rd_almost_full(afu_rd_almost_full),
        .afu_rsp_valid(afu_rsp_valid),
        .afu_rsp_tag(afu_rsp_tag),
        .afu_rsp_data(afu_rsp_data),
        .mem_rd_valid(mem_rd_valid),
        .mem_rd_addr(mem_rd_addr),
        .mem_rd_tag(mem_rd_tag),
        .mem_rd_almost_full(mem_rd_almost_full),
        .mem_rsp_valid(mem_rsp_valid),
        .mem_rsp_tag(mem_rsp_tag),
        .mem_rsp_data(mem_rsp_data),
        .inject_ready(inject_ready),
        .inj_valid(inj_valid),
        .inj_addr(inj_addr),
        .inj_slot(inj_slot),
        .head_partial(head_partial),
        .rsp_rmw_valid(rsp_rmw_valid),
        .rsp_rmw_slot(rsp_rmw_slot),
        .rsp_data(rsp_data)
    );

    write_merge wr_merge (
        .clk(clk),
        .reset(reset),
        .head(wr_head),
        .head_valid(wr_not_empty),
        .head_deq(wr_deq),
        .inject_ready(inject_ready),
        .inj_valid(inj_valid),
        .inj_addr(inj_addr),
        .inj_slot(inj_slot),
        .head_partial(head_partial),
        .has_free(has_free),
        .free_slot(free_slot),
        .alloc(alloc),
        .alloc_req(alloc_req),
        .lookup(lookup),
        .lookup_slot(lookup_slot),
        .park_valid(park_valid),
        .park_req(park_req),
        .rsp_rmw_valid(rsp_rmw_valid),
        .rsp_rmw_slot(rsp_rmw_slot),
        .rsp_data(rsp_data),
        .mem_wr_almost_full(mem_wr_almost_full),
        .mem_wr_valid(mem_wr_valid),
        .mem_wr_addr(mem_wr_addr),
        .mem_wr_data(mem_wr_data)
    );

endmodule

/* source/write_merge.sv */
/*
 * Write scheduler and merge
 * Sends full writes from the FIFO head, turns partial writes into an
 * injected read, merges the returned line and queues the result
 */

`timescale 1ns/100ps

module write_merge (
    input  logic                clk,
    input  logic                reset,

    input  pwrite_pkg::t_wr_req head,
    input  logic                head_valid,
    output logic                head_deq,

    input  logic                inject_ready,
    output logic                inj_valid,
    output pwrite_pkg::t_addr   inj_addr,
    output pwrite_pkg::t_slot   inj_slot,
    output logic                head_partial,

    input  logic                has_free,
    input  pwrite_pkg::t_slot   free_slot,
    output logic                alloc,
    output pwrite_pkg::t_wr_req alloc_req,
    output logic                lookup,
    output pwrite_pkg::t_slot   lookup_slot,
    input  logic                park_valid,
    input  pwrite_pkg::t_wr_req park_req,

    input  logic                rsp_rmw_valid,
    input  pwrite_pkg::t_slot   rsp_rmw_slot,
    input  pwrite_pkg::t_line   rsp_data,

    input  logic                mem_wr_almost_full,
    output logic                mem_wr_valid,
    output pwrite_pkg::t_addr   mem_wr_addr,
    output pwrite_pkg::t_line   mem_wr_data
);
    import pwrite_pkg::*;

    logic head_is_full;
    logic full_deq;
    t_line rsp_data_q;
    t_merged_wr mrg_in;
    t_merged_wr mrg_first;
    logic mrg_not_empty;
    logic mrg_deq;
    logic mrg_almost_full;

    // ====================
    // Head scheduling
    // ====================

    assign head_is_full = (head.mask == FULL_MASK);
    assign head_partial = head_valid && !head_is_full;

    // Injection also waits for an empty merge queue, which bounds the
    // queue to the parked writes plus the one being merged
    assign inj_valid = head_partial && inject_ready && has_free && !mrg_not_empty;
    assign inj_addr = head.addr;
    assign inj_slot = free_slot;
    assign alloc = inj_valid;
    assign alloc_req = head;

    // Merged writes go first, so a full write only leaves when none waits
    assign mrg_deq = mrg_not_empty && !mem_wr_almost_full;
    assign full_deq = head_valid && head_is_full && !mem_wr_almost_full && !mrg_not_empty;
    assign head_deq = inj_valid || full_deq;

    // ====================
    // Merge
    // ====================

    assign lookup = rsp_rmw_valid;
    assign lookup_slot = rsp_rmw_slot;

    // Old line is held one cycle so it lines up with the parked request
    always_ff @(posedge clk)
    begin
        rsp_data_q <= rsp_data;
    end

    always_comb
    begin
        mrg_in.addr = park_req.addr;
        for (int i = 0; i < LINE_BYTES; i++)
        begin
            // New byte where the mask is set, old byte elsewhere
            mrg_in.data[8*i +: 8] = park_req.mask[i] ? park_req.data[8*i +: 8]
                                                     : rsp_data_q[8*i +: 8];
        end
    end

    req_fifo #(
        .t_payload(t_merged_wr),
        .DEPTH(N_SLOTS + ALMOST_FULL_SLACK + 2)
    ) mrg_fifo (
        .clk(clk),
        .reset(reset),
        .enq(park_valid),
        .enq_data(mrg_in),
        .almost_full(mrg_almost_full),
        .first(mrg_first),
        .not_empty(mrg_not_empty),
        .deq(mrg_deq)
    );

    // Registered memory write port
    always_ff @(posedge clk)
    begin
        mem_wr_addr <= mrg_deq ? mrg_first.addr : head.addr;
        mem_wr_data <= mrg_deq ? mrg_first.data : head.data;
        if (reset)
        begin
            mem_wr_valid <= 1'b0;
        end
        else
        begin
            mem_wr_valid <= mrg_deq || full_deq;
        end
    end

    // Heap size and injection gating keep the merge queue short of its level
    a_mrg_room: assert property (@(posedge clk) disable iff (reset)
        !mrg_almost_full)
        else $error("write_merge: merge queue reached almost-full");

endmodule

/* source/read_port_mux.sv */
/*
 * Read port multiplexer
 * Passes AFU reads through, slips tagged reads for partial writes into
 * idle cycles, and steers tagged responses away from the AFU
 */

`timescale 1ns/100ps

module read_port_mux (
    input  logic              clk,
    input  logic              reset,

    input  logic              afu_rd_valid,
    input  pwrite_pkg::t_addr afu_rd_addr,
    input  pwrite_pkg::t_tag  afu_rd_tag,
    output logic              afu_rd_almost_full,
    output logic              afu_rsp_valid,
    output pwrite_pkg::t_tag  afu_rsp_tag,
    output pwrite_pkg::t_line afu_rsp_data,

    output logic              mem_rd_valid,
    output pwrite_pkg::t_addr mem_rd_addr,
    output pwrite_pkg::t_tag  mem_rd_tag,
    input  logic              mem_rd_almost_full,
    input  logic              mem_rsp_valid,
    input  pwrite_pkg::t_tag  mem_rsp_tag,
    input  pwrite_pkg::t_line mem_rsp_data,

    output logic              inject_ready,
    input  logic              inj_valid,
    input  pwrite_pkg::t_addr inj_addr,
    input  pwrite_pkg::t_slot inj_slot,
    input  logic              head_partial,

    output logic              rsp_rmw_valid,
    output pwrite_pkg::t_slot rsp_rmw_slot,
    output pwrite_pkg::t_line rsp_data
);
    import pwrite_pkg::*;

    logic ready_q;
    logic head_partial_q;
    logic rsp_is_rmw;
    t_tag inj_tag;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            ready_q <= 1'b0;
            head_partial_q <= 1'b0;
        end
        else
        begin
            ready_q <= !mem_rd_almost_full;
            head_partial_q <= head_partial;
        end
    end

    // Hold the AFU off while a partial write waits, which frees a read cycle
    assign afu_rd_almost_full = mem_rd_almost_full || head_partial_q;
    assign inject_ready = ready_q && !afu_rd_valid;

    // Injected reads carry the reserved bit and the heap slot in the low bits
    always_comb
    begin
        inj_tag = '0;
        inj_tag[RMW_TAG_BIT] = 1'b1;
        inj_tag[SLOT_BITS-1:0] = inj_slot;
    end

    assign mem_rd_valid = afu_rd_valid || inj_valid;
    assign mem_rd_addr = inj_valid ? inj_addr : afu_rd_addr;
    assign mem_rd_tag = inj_valid ? inj_tag : afu_rd_tag;

    // ====================
    // Response split
    // ====================

    assign rsp_is_rmw = mem_rsp_tag[RMW_TAG_BIT];

    assign afu_rsp_valid = mem_rsp_valid && !rsp_is_rmw;
    assign afu_rsp_tag = mem_rsp_tag;
    assign afu_rsp_data = mem_rsp_data;

    assign rsp_rmw_valid = mem_rsp_valid && rsp_is_rmw;
    assign rsp_rmw_slot = mem_rsp_tag[SLOT_BITS-1:0];
    assign rsp_data = mem_rsp_data;

    a_afu_tag_free: assert property (@(posedge clk) disable iff (reset)
        afu_rd_valid |-> !afu_rd_tag[RMW_TAG_BIT])
        else $error("read_port_mux: AFU read uses the reserved tag bit");

    // The write side only injects in cycles the AFU left free
    a_inject_idle: assert property (@(posedge clk) disable iff (reset)
        inj_valid |-> !afu_rd_valid)
        else $error("read_port_mux: injected read collides with AFU read");

endmodule

/* source/rmw_slot_heap.sv */
/*
 * Slot heap for parked partial writes
 * Hands out the lowest free slot, holds one write per slot while its read
 * is outstanding, and returns and frees it when the read data arrives
 */

`timescale 1ns/100ps

module rmw_slot_heap (
    input  logic               clk,
    input  logic               reset,

    // The allocation side serves the injected reads
    output logic               has_free,
    output pwrite_pkg::t_slot  free_slot,
    input  logic               alloc,
    input  pwrite_pkg::t_wr_req alloc_req,

    // The lookup side answers the tagged read response
    input  logic               lookup,
    input  pwrite_pkg::t_slot  lookup_slot,
    output logic               park_valid,
    output pwrite_pkg::t_wr_req park_req
);
    import pwrite_pkg::*;

    // One bit per slot, set while a partial write waits in that slot
    logic [N_SLOTS-1:0] busy;

    // One parked request per slot
    t_wr_req storage [N_SLOTS];

    assign has_free = !(&busy);

    // Priority encoder picks the lowest numbered free slot
    always_comb
    begin
        free_slot = '0;
        for (int i = N_SLOTS - 1; i >= 0; i--)
        begin
            if (!busy[i])
            begin
                free_slot = t_slot'(i);
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (alloc)
        begin
            storage[free_slot] <= alloc_req;
        end

        // The parked request comes out one cycle after the lookup
        park_req <= storage[lookup_slot];
    end

    // An allocated slot is always free and a looked up slot always busy,
    // so the two updates never touch the same bit in one cycle
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            busy <= '0;
            park_valid <= 1'b0;
        end
        else
        begin
            if (alloc)
            begin
                busy[free_slot] <= 1'b1;
            end
            if (lookup)
            begin
                busy[lookup_slot] <= 1'b0;
            end
            park_valid <= lookup;
        end
    end

    // A tagged response must belong to a write still parked here
    a_lookup_busy: assert property (@(posedge clk) disable iff (reset)
        lookup |-> busy[lookup_slot])
        else $error("rmw_slot_heap: lookup of a free slot");

    a_alloc_free: assert property (@(posedge clk) disable iff (reset)
        alloc |-> has_free)
        else $error("rmw_slot_heap: alloc with no free slot");

endmodule

/* source/req_fifo.sv */
/*
 * Request FIFO
 * Circular buffer for any payload type, with an almost-full level that
 * leaves room for the requests a sender may still issue
 */

`timescale 1ns/100ps

module req_fifo #(
    parameter type t_payload = logic,
    parameter int DEPTH = 8
) (
    input  logic     clk,
    input  logic     reset,

    input  logic     enq,
    input  t_payload enq_data,
    output logic     almost_full,

    output t_payload first,
    output logic     not_empty,
    input  logic     deq
);
    import pwrite_pkg::*;

    typedef logic [$clog2(DEPTH)-1:0] t_ptr;
    typedef logic [$clog2(DEPTH+1)-1:0] t_count;

    // Payload storage with a write pointer, a read pointer and an entry count
    t_payload mem [DEPTH];
    t_ptr wr_ptr;
    t_ptr rd_ptr;
    t_count count;

    assign first = mem[rd_ptr];
    assign not_empty = (count != '0);

    // Raised while no more than the slack worth of entries is free
    assign almost_full = (DEPTH - int'(count)) <= ALMOST_FULL_SLACK;

    always_ff @(posedge clk)
    begin
        if (enq)
        begin
            mem[wr_ptr] <= enq_data;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end
        else
        begin
            // Pointers wrap explicitly so DEPTH need not be a power of two
            if (enq)
            begin
                wr_ptr <= (int'(wr_ptr) == DEPTH - 1) ? '0 : wr_ptr + t_ptr'(1);
            end
            if (deq)
            begin
                rd_ptr <= (int'(rd_ptr) == DEPTH - 1) ? '0 : rd_ptr + t_ptr'(1);
            end
            if (enq && !deq)
            begin
                count <= count + t_count'(1);
            end
            else if (deq && !enq)
            begin
                count <= count - t_count'(1);
            end
        end
    end

    // The sender must honor almost-full, so the buffer never overflows
    a_no_overflow: assert property (@(posedge clk) disable iff (reset)
        enq && !deq |-> int'(count) < DEPTH)
        else $error("req_fifo: enqueue while full");

    a_no_underflow: assert property (@(posedge clk) disable iff (reset)
        deq |-> not_empty)
        else $error("req_fifo: dequeue while empty");

endmodule

/* source/pwrite_pkg.sv */
/*
 * Partial write shim definitions
 * Line, mask and tag widths, the tag bit that marks injected reads,
 * flow control slack and the request records carried through the shim
 */

package pwrite_pkg;

    // ====================
    // Widths
    // ====================

    localparam int ADDR_BITS = 16;
    localparam int LINE_BYTES = 8;
    localparam int TAG_BITS = 8;

    // Tag bit that marks reads generated by the shim; the AFU keeps it zero
    localparam int RMW_TAG_BIT = 7;

    // Partial writes that may wait for their read data at one time
    localparam int N_SLOTS = 8;
    localparam int SLOT_BITS = 3;

    // Requests a sender may still issue once almost-full has risen
    localparam int ALMOST_FULL_SLACK = 4;

    // Depth of the FIFO that buffers incoming AFU writes
    localparam int WR_FIFO_DEPTH = 8;

    typedef logic [ADDR_BITS-1:0] t_addr;
    typedef logic [8*LINE_BYTES-1:0] t_line;
    typedef logic [LINE_BYTES-1:0] t_mask;
    typedef logic [TAG_BITS-1:0] t_tag;
    typedef logic [SLOT_BITS-1:0] t_slot;

    // A write mask with every byte enabled is a full-line write
    localparam t_mask FULL_MASK = '1;

    // One AFU write as it is buffered and parked
    typedef struct packed {
        t_addr addr;
        t_line data;
        t_mask mask;
    } t_wr_req;

    // One finished full-line write waiting for the memory write port
    typedef struct packed {
        t_addr addr;
        t_line data;
    } t_merged_wr;

endpackage
